// ==== verilog/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// word address width
`define ADDR_W 8
`define WORD_W 32

`define WORDS_PER_LINE 4
`define SETS 8
`define MEM_LINES 64

// cycles from mem_req rising to main_mem_ack
`define MEM_LATENCY 3

// address split
`define OFFSET_W $clog2(`WORDS_PER_LINE)
`define INDEX_W $clog2(`SETS)
`define TAG_W (`ADDR_W - `INDEX_W - `OFFSET_W)
`define LINE_ADDR_W (`ADDR_W - `OFFSET_W)

`endif

// ==== verilog/cache_types_pkg.sv ====
`include "cache_defines.svh"

package cache_types_pkg;

	// word address as seen by the cache
	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [`INDEX_W-1:0] index;
		logic [`OFFSET_W-1:0] offset;
	} addr_t;

	typedef logic [`WORD_W-1:0] word_t;

	// one cache or memory line, word 0 in the low bits
	typedef word_t [`WORDS_PER_LINE-1:0] line_t;

	// tag store entry
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`TAG_W-1:0] tag;
	} tag_entry_t;

endpackage

// ==== verilog/bus_pkg.sv ====
`include "cache_defines.svh"

package bus_pkg;

	import cache_types_pkg::*;

	// cpu side request
	typedef struct packed {
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// memory side request, whole lines only
	typedef struct packed {
		logic [`LINE_ADDR_W-1:0] line_addr;
		line_t wdata;
	} mem_req_t;

endpackage

// ==== verilog/cache_array.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_array import cache_types_pkg::*; #(
	parameter type entry_t = line_t,
	parameter int DEPTH = `SETS,
	parameter bit INIT_PATTERN = 1'b0
) (
	input logic clk,
	input logic n_rst,
	input logic [$clog2(DEPTH)-1:0] index,
	input logic wr_en,
	input entry_t wdata,
	output entry_t rdata
);

	entry_t mem [DEPTH];

	// each word holds its own word address in both halves
	function automatic line_t pattern_line(input int line);
		line_t l;
		logic [15:0] word_addr;
		for (int w = 0; w < `WORDS_PER_LINE; w++) begin
			word_addr = 16'(line * `WORDS_PER_LINE + w);
			l[w] = {word_addr, word_addr};
		end
		return l;
	endfunction

	assign rdata = mem[index];

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				if (INIT_PATTERN)
					mem[i] <= entry_t'(pattern_line(i));
				else
					mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[index] <= wdata;
		end
	end

endmodule

// ==== verilog/cache_controller.sv ====
`timescale 1ns/100ps

module cache_controller (
	input logic clk,
	input logic n_rst,

	// cpu side
	input logic cpu_req,
	input logic cpu_rw,	// 1 write, 0 read
	input logic cpu_flush,

	// from datapath and memory
	input logic cache_hit,
	input logic dirty_bit,
	input logic flush_done,
	input logic main_mem_ack,

	output logic cpu_wr_req,
	output logic flush_req,
	output logic flush,
	output logic flush_count_en,
	output logic cache_wr_en,
	output logic mem_rw,	// 1 write-back, 0 refill
	output logic mem_req,
	output logic cache_ready
);

	typedef enum logic [2:0] {
		s_idle,
		s_process_req,
		s_allocate,
		s_writeback,
		s_flush
	} state_e;

	state_e state, next;
	logic flushing;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= s_idle;
		else
			state <= next;
	end

	// remembers whether a write-back belongs to a flush
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			flushing <= 1'b0;
		else if (state == s_idle)
			flushing <= cpu_flush && !cpu_req;
	end

	always_comb begin
		next = state;
		case (state)
			s_idle: begin
				if (cpu_req)
					next = s_process_req;
				else if (cpu_flush)
					next = s_flush;
			end
			s_process_req: begin
				if (cache_hit)
					next = s_idle;
				else if (dirty_bit)
					next = s_writeback;
				else
					next = s_allocate;
			end
			s_allocate: begin
				if (main_mem_ack)
					next = s_process_req;
			end
			s_writeback: begin
				if (main_mem_ack)
					next = flushing ? s_flush : s_allocate;
			end
			s_flush: begin
				if (flush_done)
					next = s_idle;
				else if (dirty_bit)
					next = s_writeback;
			end
			default: next = s_idle;
		endcase
	end

	always_comb begin
		cpu_wr_req = 1'b0;
		flush_req = 1'b0;
		flush = 1'b0;
		flush_count_en = 1'b0;
		cache_wr_en = 1'b0;
		mem_rw = 1'b0;
		mem_req = 1'b0;
		cache_ready = 1'b0;
		case (state)
			s_idle: begin
				cache_ready = !(cpu_req || cpu_flush);
				flush_req = cpu_flush && !cpu_req;
			end
			s_process_req: begin
				if (cache_hit) begin
					cache_ready = 1'b1;
					cpu_wr_req = cpu_rw;
					cache_wr_en = cpu_rw;
				end
			end
			s_allocate: begin
				mem_req = 1'b1;
				// refill line lands on the ack
				cache_wr_en = main_mem_ack;
			end
			s_writeback: begin
				mem_req = 1'b1;
				mem_rw = 1'b1;
				flush = flushing;
				// clears the dirty flag
				cache_wr_en = main_mem_ack;
			end
			s_flush: begin
				flush = 1'b1;
				cache_ready = flush_done;
				flush_count_en = !flush_done && !dirty_bit;
			end
			default: begin
				cache_ready = 1'b0;
			end
		endcase
	end

endmodule

// ==== verilog/cache_datapath.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_datapath import cache_types_pkg::*, bus_pkg::*; (
	input logic clk,
	input logic n_rst,

	input cpu_req_t cpu_req_data,

	// from controller
	input logic cpu_wr_req,
	input logic cache_wr_en,
	input logic mem_rw,
	input logic flush_req,
	input logic flush,
	input logic flush_count_en,

	// from memory
	input logic main_mem_ack,
	input line_t mem_rdata,

	output logic cache_hit,
	output logic dirty_bit,
	output logic flush_done,
	output word_t cpu_rdata,
	output mem_req_t mem_req_data
);

	localparam int INDEX_W = `INDEX_W;
	localparam logic [INDEX_W-1:0] LAST_SET = INDEX_W'(`SETS - 1);

	addr_t addr;
	logic [INDEX_W-1:0] index;
	logic [INDEX_W-1:0] flush_cnt;
	tag_entry_t tag_rd, tag_wr;
	line_t line_rd, line_wr, line_merged;

	assign addr = cpu_req_data.addr;

	// flush walks the sets by counter
	assign index = flush ? flush_cnt : addr.index;

	assign cache_hit = tag_rd.valid && (tag_rd.tag == addr.tag);
	assign dirty_bit = tag_rd.valid && tag_rd.dirty;
	assign flush_done = (flush_cnt == LAST_SET) && !dirty_bit;
	assign cpu_rdata = line_rd[addr.offset];

	always_comb begin
		line_merged = line_rd;
		line_merged[addr.offset] = cpu_req_data.wdata;
	end

	// write-back ack, refill ack, or cpu write hit
	always_comb begin
		tag_wr = tag_rd;
		line_wr = line_rd;
		if (main_mem_ack && mem_rw) begin
			tag_wr.dirty = 1'b0;
		end else if (main_mem_ack) begin
			tag_wr = '{valid: 1'b1, dirty: 1'b0, tag: addr.tag};
			line_wr = mem_rdata;
		end else if (cpu_wr_req) begin
			tag_wr.dirty = 1'b1;
			line_wr = line_merged;
		end
	end

	// victim address comes from the stored tag
	assign mem_req_data = '{
		line_addr: mem_rw ? {tag_rd.tag, index} : {addr.tag, addr.index},
		wdata: line_rd
	};

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			flush_cnt <= '0;
		else if (flush_req)
			flush_cnt <= '0;
		else if (flush_count_en)
			flush_cnt <= flush_cnt + 1'b1;
	end

	cache_array #(
		.entry_t(tag_entry_t),
		.DEPTH(`SETS)
	) i_tag_array (
		.clk(clk),
		.n_rst(n_rst),
		.index(index),
		.wr_en(cache_wr_en),
		.wdata(tag_wr),
		.rdata(tag_rd)
	);

	cache_array #(
		.entry_t(line_t),
		.DEPTH(`SETS)
	) i_data_array (
		.clk(clk),
		.n_rst(n_rst),
		.index(index),
		.wr_en(cache_wr_en),
		.wdata(line_wr),
		.rdata(line_rd)
	);

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module main_memory import cache_types_pkg::*, bus_pkg::*; (
	input logic clk,
	input logic n_rst,
	input logic mem_req,
	input logic mem_rw,
	input mem_req_t mem_req_data,
	output logic main_mem_ack,
	output line_t mem_rdata
);

	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);
	localparam logic [CNT_W-1:0] ACK_COUNT = CNT_W'(`MEM_LATENCY);

	logic [CNT_W-1:0] lat_cnt;

	// restarts after every ack, so back-to-back requests each wait
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			lat_cnt <= '0;
		else if (!mem_req || main_mem_ack)
			lat_cnt <= '0;
		else
			lat_cnt <= lat_cnt + 1'b1;
	end

	assign main_mem_ack = mem_req && (lat_cnt == ACK_COUNT);

	// read data is presented combinationally, taken on the ack
	cache_array #(
		.entry_t(line_t),
		.DEPTH(`MEM_LINES),
		.INIT_PATTERN(1'b1)
	) i_mem_array (
		.clk(clk),
		.n_rst(n_rst),
		.index(mem_req_data.line_addr),
		.wr_en(main_mem_ack && mem_rw),
		.wdata(mem_req_data.wdata),
		.rdata(mem_rdata)
	);

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_top import cache_types_pkg::*, bus_pkg::*; (
	input logic clk,
	input logic n_rst,
	input logic cpu_req,
	input logic cpu_rw,
	input logic cpu_flush,
	input cpu_req_t cpu_req_data,
	output word_t cpu_rdata,
	output logic cache_ready
);

	logic cpu_wr_req, cache_wr_en, mem_rw;
	logic flush_req, flush, flush_count_en;
	logic cache_hit, dirty_bit, flush_done;
	logic mem_req, main_mem_ack;
	mem_req_t mem_req_data;
	line_t mem_rdata;

	cache_controller i_cache_controller (
		.clk(clk),
		.n_rst(n_rst),
		.cpu_req(cpu_req),
		.cpu_rw(cpu_rw),
		.cpu_flush(cpu_flush),
		.cache_hit(cache_hit),
		.dirty_bit(dirty_bit),
		.flush_done(flush_done),
		.main_mem_ack(main_mem_ack),
		.cpu_wr_req(cpu_wr_req),
		.flush_req(flush_req),
		.flush(flush),
		.flush_count_en(flush_count_en),
		.cache_wr_en(cache_wr_en),
		.mem_rw(mem_rw),
		.mem_req(mem_req),
		.cache_ready(cache_ready)
	);

	cache_datapath i_cache_datapath (
		.clk(clk),
		.n_rst(n_rst),
		.cpu_req_data(cpu_req_data),
		.cpu_wr_req(cpu_wr_req),
		.cache_wr_en(cache_wr_en),
		.mem_rw(mem_rw),
		.flush_req(flush_req),
		.flush(flush),
		.flush_count_en(flush_count_en),
		.main_mem_ack(main_mem_ack),
		.mem_rdata(mem_rdata),
		.cache_hit(cache_hit),
		.dirty_bit(dirty_bit),
		.flush_done(flush_done),
		.cpu_rdata(cpu_rdata),
		.mem_req_data(mem_req_data)
	);

	main_memory i_main_memory (
		.clk(clk),
		.n_rst(n_rst),
		.mem_req(mem_req),
		.mem_rw(mem_rw),
		.mem_req_data(mem_req_data),
		.main_mem_ack(main_mem_ack),
		.mem_rdata(mem_rdata)
	);

endmodule

// ==== bench/cache_assert.sv ====
`timescale 1ns/100ps

module cache_assert (
	input logic clk,
	input logic n_rst,
	input logic mem_req,
	input logic main_mem_ack,
	input logic cache_ready,
	input logic cpu_wr_req,
	input logic cache_hit
);

	int fail_count = 0;

	// cpu never sees ready while memory is busy
	a_ready_while_busy: assert property (@(posedge clk) disable iff (!n_rst)
		!(mem_req && cache_ready))
		else begin
			fail_count++;
			$error("mem_req and cache_ready high in the same cycle");
		end

	a_ack_without_req: assert property (@(posedge clk) disable iff (!n_rst)
		main_mem_ack |-> mem_req)
		else begin
			fail_count++;
			$error("main_mem_ack without mem_req");
		end

	// word merge only into a matching line
	a_write_on_hit: assert property (@(posedge clk) disable iff (!n_rst)
		cpu_wr_req |-> cache_hit)
		else begin
			fail_count++;
			$error("cpu_wr_req without cache_hit");
		end

endmodule

bind cache_controller cache_assert i_cache_assert (
	.clk(clk),
	.n_rst(n_rst),
	.mem_req(mem_req),
	.main_mem_ack(main_mem_ack),
	.cache_ready(cache_ready),
	.cpu_wr_req(cpu_wr_req),
	.cache_hit(cache_hit)
);

// ==== bench/cache_tb.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_tb import cache_types_pkg::*, bus_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int OP_CYCLES = 2 * `MEM_LATENCY + 6;
	// request sampled in idle, ready in process request
	localparam int HIT_CYCLES = 2;

	logic clk;
	logic n_rst;
	logic cpu_req;
	logic cpu_rw;
	logic cpu_flush;
	cpu_req_t cpu_req_data;
	word_t cpu_rdata;
	logic cache_ready;

	// operations from the data file
	byte op_q[$];
	logic [`ADDR_W-1:0] addr_q[$];
	word_t wdata_q[$];
	word_t expect_q[$];

	// line held by each set, used to tell hits from misses
	logic set_valid [`SETS];
	logic [`TAG_W-1:0] set_tag [`SETS];

	int budget_cycles;
	bit budget_set;
	int tests_run;
	int tests_failed;

	cache_top i_cache_top (
		.clk(clk),
		.n_rst(n_rst),
		.cpu_req(cpu_req),
		.cpu_rw(cpu_rw),
		.cpu_flush(cpu_flush),
		.cpu_req_data(cpu_req_data),
		.cpu_rdata(cpu_rdata),
		.cache_ready(cache_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic load_stimulus(output bit ok);
		int fd;
		int n;
		string text;
		byte op;
		logic [`ADDR_W-1:0] a;
		word_t wd;
		word_t ex;
		ok = 1'b0;
		fd = $fopen("bench/cache_input.txt", "r");
		if (fd == 0)
			return;
		while ($fgets(text, fd) != 0) begin
			if (text.len() < 2 || text.substr(0, 1) == "//")
				continue;
			n = $sscanf(text, "%c %h %h %h", op, a, wd, ex);
			if (n == 4 && (op == "R" || op == "W" || op == "F")) begin
				op_q.push_back(op);
				addr_q.push_back(a);
				wdata_q.push_back(wd);
				expect_q.push_back(ex);
			end
		end
		$fclose(fd);
		ok = (op_q.size() > 0);
	endtask

	task automatic run_op(input byte op, input logic [`ADDR_W-1:0] a, input word_t wd,
			input word_t ex);
		int cycles;
		bit failed;
		bit expect_hit;
		addr_t addr;
		addr = addr_t'(a);
		failed = 1'b0;
		expect_hit = (op != "F") && set_valid[addr.index] && (set_tag[addr.index] == addr.tag);
		cpu_req_data <= '{addr: addr, wdata: wd};
		cpu_rw <= (op == "W");
		if (op == "F")
			cpu_flush <= 1'b1;
		else
			cpu_req <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!cache_ready);
		cpu_req <= 1'b0;
		cpu_flush <= 1'b0;
		if (op == "R" && cpu_rdata !== ex) begin
			$display("Mismatch cpu_rdata at address %h: expected %h, actual %h",
				a, ex, cpu_rdata);
			failed = 1'b1;
		end
		if (expect_hit && cycles != HIT_CYCLES) begin
			$display("hit at address %h took %0d cycles instead of %0d",
				a, cycles, HIT_CYCLES);
			failed = 1'b1;
		end
		if (op != "F" && !expect_hit && cycles <= HIT_CYCLES) begin
			$display("miss at address %h finished in %0d cycles, without a memory access",
				a, cycles);
			failed = 1'b1;
		end
		if (op != "F") begin
			set_valid[addr.index] = 1'b1;
			set_tag[addr.index] = addr.tag;
		end
		tests_run++;
		if (failed)
			tests_failed++;
		$display("test %0d: %c %h %s", tests_run, op, a, failed ? "error" : "ok");
		@(posedge clk);
	endtask

	// ends the run if the operations take longer than their budget
	initial begin
		wait (budget_set);
		repeat (budget_cycles) @(posedge clk);
		$display("watchdog: operations still running after %0d cycles", budget_cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		bit ok;
		int assert_failures;
		n_rst = 1'b0;
		cpu_req = 1'b0;
		cpu_rw = 1'b0;
		cpu_flush = 1'b0;
		cpu_req_data = '0;
		tests_run = 0;
		tests_failed = 0;
		budget_set = 1'b0;
		foreach (set_valid[i]) begin
			set_valid[i] = 1'b0;
			set_tag[i] = '0;
		end
		load_stimulus(ok);
		if (!ok) begin
			$display("could not read any operation from bench/cache_input.txt");
			$display("Test failed");
			$finish;
		end
		budget_cycles = RESET_CYCLES + 2;
		foreach (op_q[i])
			budget_cycles += (op_q[i] == "F") ? OP_CYCLES * `SETS : OP_CYCLES;
		budget_set = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		n_rst <= 1'b1;
		@(posedge clk);
		tests_run++;
		if (cache_ready !== 1'b1) begin
			$display("cache_ready is low after reset, before any request");
			tests_failed++;
			$display("test %0d: ready after reset error", tests_run);
		end else begin
			$display("test %0d: ready after reset ok", tests_run);
		end

		foreach (op_q[i])
			run_op(op_q[i], addr_q[i], wdata_q[i], expect_q[i]);

		assert_failures = i_cache_top.i_cache_controller.i_cache_assert.fail_count;
		if (assert_failures != 0)
			$display("%0d assertion failures in the cache controller", assert_failures);

		$display("%0d tests run, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && assert_failures == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== bench/cache_input.txt ====
// columns: op (R read, W write, F flush), word address, write data, expected read data
// memory starts with every word holding its word address in both 16-bit halves
R 00 00000000 00000000
R 05 00000000 00050005
R 06 00000000 00060006
W 04 deadbeef 00000000
R 04 00000000 deadbeef
R 07 00000000 00070007
R 24 00000000 00240024
R 04 00000000 deadbeef
R 04 00000000 deadbeef
W 09 a5a5a5a5 00000000
W 0e 12345678 00000000
W 1d cafef00d 00000000
R 0e 00000000 12345678
F 00 00000000 00000000
R 29 00000000 00290029
R 09 00000000 a5a5a5a5
R 2e 00000000 002e002e
R 0e 00000000 12345678
R 3d 00000000 003d003d
R 1d 00000000 cafef00d
R 08 00000000 00080008

// ==== build.f ====
+incdir+verilog
verilog/cache_types_pkg.sv
verilog/bus_pkg.sv
verilog/cache_array.sv
verilog/cache_controller.sv
verilog/cache_datapath.sv
verilog/main_memory.sv
verilog/cache_top.sv
bench/cache_assert.sv
bench/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
